//--- list.f
gamePkg.sv
frameMemory.sv
sceneController.sv
pixelAddressGen.sv
pixelCompositor.sv
colorMapper.sv
colorMapper_checker.sv
colorMapperTb.sv

//--- run.sh
#!/bin/sh
# Build and run the colorMapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module colorMapperTb \
	-f list.f -o colorMapperSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/colorMapperSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0

//--- colorMapperTb.sv
`timescale 1ns/1ps

module colorMapperTb;

	import gamePkg::*;

	typedef struct packed {
		logic valid;
		rgb_t color;
	} expPixel_t;

	logic Clk;
	logic rstN;
	logic frameTick;
	logic [7:0] keycode;
	logic moving;
	direction_t direction;
	screenCoord_t drawX;
	screenCoord_t drawY;
	logic blank;
	loadReq_t load;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	// Reference copies of the memories
	spriteIndex_t sheetRef [6612];
	colorIndex_t mapRef [76800];
	colorIndex_t menuRef [76800];
	rgb_t paletteRef [256];

	// Scene model
	logic mOverworld;
	int mCamX;
	int mCamY;
	int mCnt;
	direction_t mFacing;
	walkStep_t mStep;

	int unsigned lcgState;
	expPixel_t stim;
	expPixel_t expQ[$];

	colorMapper #(
		.MapDepth(76800),
		.MenuDepth(76800),
		.SheetDepth(6612)
	) i_dut (
		.Clk(Clk),
		.rstN(rstN),
		.frameTick(frameTick),
		.keycode(keycode),
		.moving(moving),
		.direction(direction),
		.drawX(drawX),
		.drawY(drawY),
		.blank(blank),
		.load(load),
		.red(red),
		.green(green),
		.blue(blue)
	);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	function automatic int unsigned lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int randRange(int n);
		return int'((lcgNext() >> 8) % n);
	endfunction

	// Built from the upper bits of two LCG draws
	function automatic rgb_t randWord();
		int unsigned hi;
		int unsigned lo;
		hi = lcgNext();
		lo = lcgNext();
		return {hi[31:24], lo[31:16]};
	endfunction

	function automatic int sheetColumn(direction_t f, walkStep_t s);
		int base;
		int add;
		case (f)
			dirDown: base = 0;
			dirLeft: base = 57;
			dirUp: base = 114;
			default: base = 171;
		endcase
		case (s)
			stepMove1: add = 0;
			stepMove2: add = 38;
			default: add = 19;
		endcase
		return base + add;
	endfunction

	function automatic rgb_t expectPixel(int x, int y, logic vis);
		int mx;
		int my;
		int s;
		if (!vis) return '0;
		if (!mOverworld) return paletteRef[menuRef[(y / 2) * 320 + x / 2]];
		mx = x + mCamX;
		my = y + mCamY;
		if (mx < 0 || my < 0 || mx / 4 >= 320 || my / 4 >= 240) return '0;
		if (x >= 311 && x <= 329 && y >= 340 && y <= 368) begin
			s = sheetRef[228 * (y - 340) + (x - 311) + sheetColumn(mFacing, mStep)];
			if (s != 0) return paletteRef[s];
		end
		return paletteRef[mapRef[(my / 4) * 320 + mx / 4]];
	endfunction

	function automatic logic pendingValid();
		logic any;
		any = stim.valid;
		foreach (expQ[j]) any = any | expQ[j].valid;
		return any;
	endfunction

	task automatic nextCycle();
		@(posedge Clk);
		#2;
		frameTick = 1'b0;
		load.valid = 1'b0;
		stim.valid = 1'b0;
	endtask

	task automatic showPixel(int x, int y, logic vis);
		nextCycle();
		drawX = screenCoord_t'(x);
		drawY = screenCoord_t'(y);
		blank = vis;
		stim = '{valid: 1'b1, color: expectPixel(x, y, vis)};
	endtask

	task automatic loadWord(memTarget_t target, int addr, rgb_t data);
		nextCycle();
		load = '{valid: 1'b1, target: target, addr: imageAddr_t'(addr), data: data};
	endtask

	// Each memory keeps only its own low bits of the data word
	task automatic fillMemories();
		int i;
		rgb_t w;
		for (i = 0; i < 256; i++) begin
			paletteRef[i] = randWord();
			loadWord(targetPalette, i, paletteRef[i]);
		end
		for (i = 0; i < 6612; i++) begin
			w = randWord();
			sheetRef[i] = spriteIndex_t'(w);
			loadWord(targetSprite, i, w);
		end
		for (i = 0; i < 76800; i++) begin
			w = randWord();
			mapRef[i] = colorIndex_t'(w);
			loadWord(targetMap, i, w);
			w = randWord();
			menuRef[i] = colorIndex_t'(w);
			loadWord(targetMenu, i, w);
		end
	endtask

	task automatic tick(logic [7:0] key, logic mv, direction_t dir);
		nextCycle();
		frameTick = 1'b1;
		keycode = key;
		moving = mv;
		direction = dir;
		if (!mOverworld) begin
			if (key == 8'h2c) begin
				mOverworld = 1'b1;
				mCamX = 100;
				mCamY = 100;
			end
		end else if (!mv) begin
			mStep = stepRest1;
		end else if (dir != mFacing) begin
			mFacing = dir;
			mStep = stepRest1;
		end else begin
			if (mCnt == 0) mStep = walkStep_t'((int'(mStep) + 1) % 4);
			mCnt = (mCnt + 1) % 8;
			case (mFacing)
				dirUp: if (mCamY > -340) mCamY = mCamY - 1;
				dirDown: if (mCamY < 595) mCamY = mCamY + 1;
				dirLeft: if (mCamX > -311) mCamX = mCamX - 1;
				default: if (mCamX < 952) mCamX = mCamX + 1;
			endcase
		end
	endtask

	// Around the character window and then anywhere on screen
	task automatic sampleAround(int n);
		int i;
		for (i = 0; i < n; i++) begin
			showPixel(303 + randRange(35), 332 + randRange(45), 1'b1);
		end
		for (i = 0; i < n; i++) begin
			showPixel(randRange(640), randRange(480), 1'b1);
		end
	endtask

	task automatic sweepSprite();
		int x;
		int y;
		for (y = 340; y <= 368; y++) begin
			for (x = 311; x <= 329; x++) begin
				showPixel(x, y, 1'b1);
			end
		end
	endtask

	task automatic waitDrain();
		int guard;
		guard = 0;
		while (pendingValid() && guard < 10) begin
			nextCycle();
			guard++;
		end
	endtask

	// Output of a pixel shows up three edges after it was presented
	initial begin
		expPixel_t head;
		forever begin
			@(posedge Clk);
			#1;
			expQ.push_back(stim);
			if (expQ.size() == 3) begin
				head = expQ.pop_front();
				assert (!head.valid || {red, green, blue} == head.color) else begin
					$display("[FAIL] red=%h green=%h blue=%h, expected red=%h green=%h blue=%h",
						red, green, blue, head.color[23:16], head.color[15:8], head.color[7:0]);
					$display("STATUS: FAIL");
					$fatal(1, "Pixel color mismatch");
				end
			end
		end
	end

	initial begin
		int i;
		lcgState = 20015;
		rstN = 1'b0;
		frameTick = 1'b0;
		keycode = 8'h00;
		moving = 1'b0;
		direction = dirUp;
		drawX = '0;
		drawY = '0;
		blank = 1'b0;
		load = '0;
		stim = '0;
		mOverworld = 1'b0;
		mCamX = 100;
		mCamY = 100;
		mCnt = 0;
		mFacing = dirUp;
		mStep = stepRest1;
		repeat (3) @(posedge Clk);
		#2;
		rstN = 1'b1;
		fillMemories();

		// Start menu pixels back to back
		showPixel(0, 0, 1'b1);
		showPixel(639, 479, 1'b1);
		for (i = 0; i < 300; i++) showPixel(randRange(640), randRange(480), 1'b1);
		for (i = 0; i < 200; i++) showPixel(randRange(640), randRange(480), randRange(2) == 0);

		tick(8'h1d, 1'b0, dirUp);
		sampleAround(20);
		tick(8'h2c, 1'b0, dirUp);
		sweepSprite();
		sampleAround(40);

		// Held walk up with frames changing every 8 ticks
		for (i = 0; i < 24; i++) begin
			tick(8'h00, 1'b1, dirUp);
			sampleAround(6);
		end
		tick(8'h00, 1'b1, dirRight);
		sweepSprite();

		// Walk into the left and top limits
		for (i = 0; i < 440; i++) begin
			tick(8'h00, 1'b1, dirLeft);
			if (i % 40 == 0) sampleAround(4);
		end
		sampleAround(30);
		for (i = 0; i < 440; i++) begin
			tick(8'h00, 1'b1, dirUp);
			if (i % 40 == 0) sampleAround(4);
		end
		sweepSprite();
		sampleAround(60);

		tick(8'h00, 1'b0, dirUp);
		sweepSprite();
		waitDrain();
		if (pendingValid()) begin
			$display("Timeout: pixels still in flight after the last one was presented");
			$display("STATUS: FAIL");
			$fatal(1, "Pipeline did not drain");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

//--- colorMapper_checker.sv
`timescale 1ns/1ps

module colorMapper_checker (
	input logic Clk,
	input logic rstN,
	input logic blank,
	input gamePkg::rgb_t rgb
);

	// Black while in reset
	resetBlack: assert property (@(posedge Clk) !rstN |-> rgb == '0)
		else $error("RGB output not black during reset");

	// First clocked update after release is still black
	releaseBlack: assert property (@(posedge Clk) $rose(rstN) |=> rgb == '0)
		else $error("RGB output not black in the cycle after reset");

	// Three cycle pixel latency
	blankBlack: assert property (
		@(posedge Clk) disable iff (!rstN)
		!$past(blank, 3) |-> rgb == '0
	) else $error("Blanked pixel did not come out black");

	noUnknown: assert property (
		@(posedge Clk) disable iff (!rstN)
		!$isunknown(rgb)
	) else $error("RGB output unknown after reset");

endmodule

bind colorMapper colorMapper_checker outputChecks (
	.Clk(Clk),
	.rstN(rstN),
	.blank(blank),
	.rgb(rgb)
);

//--- colorMapper.sv
`timescale 1ns/1ps

module colorMapper #(
	parameter int MapDepth = 76800,
	parameter int MenuDepth = 76800,
	parameter int SheetDepth = 6612
) (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic [7:0] keycode,
	input logic moving,
	input gamePkg::direction_t direction,
	input gamePkg::screenCoord_t drawX,
	input gamePkg::screenCoord_t drawY,
	input logic blank,
	input gamePkg::loadReq_t load,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	import gamePkg::*;

	sceneView_t view;
	imageAddr_t mapAddr;
	imageAddr_t menuAddr;
	spriteAddr_t spriteAddr;
	logic inSprite;
	logic offMap;
	spriteIndex_t spritePix;
	colorIndex_t mapPix;
	colorIndex_t menuPix;
	rgb_t rgb;

	logic spriteWe;
	logic mapWe;
	logic menuWe;
	loadReq_t paletteLoad;

	// Load target decode
	always_comb begin
		spriteWe = load.valid && (load.target == targetSprite);
		mapWe = load.valid && (load.target == targetMap);
		menuWe = load.valid && (load.target == targetMenu);
		paletteLoad = load;
		paletteLoad.valid = load.valid && (load.target == targetPalette);
	end

	sceneController scene (
		.Clk(Clk),
		.rstN(rstN),
		.frameTick(frameTick),
		.keycode(keycode),
		.moving(moving),
		.direction(direction),
		.view(view)
	);

	pixelAddressGen addrGen (
		.drawX(drawX),
		.drawY(drawY),
		.view(view),
		.mapAddr(mapAddr),
		.menuAddr(menuAddr),
		.spriteAddr(spriteAddr),
		.inSprite(inSprite),
		.offMap(offMap)
	);

	frameMemory #(
		.Depth(SheetDepth),
		.Width($bits(spriteIndex_t))
	) spriteSheet (
		.Clk(Clk),
		.we(spriteWe),
		.writeAddr(load.addr),
		.writeData(spriteIndex_t'(load.data)),
		.readAddr(imageAddr_t'(spriteAddr)),
		.readData(spritePix)
	);

	frameMemory #(
		.Depth(MapDepth),
		.Width($bits(colorIndex_t))
	) mapImage (
		.Clk(Clk),
		.we(mapWe),
		.writeAddr(load.addr),
		.writeData(colorIndex_t'(load.data)),
		.readAddr(mapAddr),
		.readData(mapPix)
	);

	frameMemory #(
		.Depth(MenuDepth),
		.Width($bits(colorIndex_t))
	) menuImage (
		.Clk(Clk),
		.we(menuWe),
		.writeAddr(load.addr),
		.writeData(colorIndex_t'(load.data)),
		.readAddr(menuAddr),
		.readData(menuPix)
	);

	pixelCompositor compositor (
		.Clk(Clk),
		.rstN(rstN),
		.view(view),
		.blank(blank),
		.inSprite(inSprite),
		.offMap(offMap),
		.spritePix(spritePix),
		.mapPix(mapPix),
		.menuPix(menuPix),
		.paletteLoad(paletteLoad),
		.rgb(rgb)
	);

	assign {red, green, blue} = rgb;

endmodule

//--- pixelCompositor.sv
`timescale 1ns/1ps

module pixelCompositor (
	input logic Clk,
	input logic rstN,
	input gamePkg::sceneView_t view,
	input logic blank,
	input logic inSprite,
	input logic offMap,
	input gamePkg::spriteIndex_t spritePix,
	input gamePkg::colorIndex_t mapPix,
	input gamePkg::colorIndex_t menuPix,
	input gamePkg::loadReq_t paletteLoad,
	output gamePkg::rgb_t rgb
);

	import gamePkg::*;

	typedef struct packed {
		logic visible;
		logic inSprite;
		logic offMap;
		logic overworld;
	} pixelFlags_t;

	pixelFlags_t flagsD1;
	logic visibleD2;
	colorIndex_t paletteIdx;
	rgb_t paletteColor;

	// Stage 1 lines the flags up with the image memory data
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			flagsD1 <= '0;
			visibleD2 <= 1'b0;
			rgb <= '0;
		end else begin
			flagsD1 <= '{
				visible: blank,
				inSprite: inSprite,
				offMap: offMap,
				overworld: view.overworld
			};
			visibleD2 <= flagsD1.visible && !(flagsD1.overworld && flagsD1.offMap);
			rgb <= visibleD2 ? paletteColor : '0;
		end
	end

	// Sprite index 0 is transparent
	always_comb begin
		if (!flagsD1.overworld) begin
			paletteIdx = menuPix;
		end else if (flagsD1.inSprite && spritePix != '0) begin
			paletteIdx = colorIndex_t'(spritePix);
		end else begin
			paletteIdx = mapPix;
		end
	end

	frameMemory #(
		.Depth(2 ** $bits(colorIndex_t)),
		.Width($bits(rgb_t))
	) palette (
		.Clk(Clk),
		.we(paletteLoad.valid),
		.writeAddr(paletteLoad.addr),
		.writeData(paletteLoad.data),
		.readAddr(imageAddr_t'(paletteIdx)),
		.readData(paletteColor)
	);

endmodule

//--- pixelAddressGen.sv
`timescale 1ns/1ps

module pixelAddressGen (
	input gamePkg::screenCoord_t drawX,
	input gamePkg::screenCoord_t drawY,
	input gamePkg::sceneView_t view,
	output gamePkg::imageAddr_t mapAddr,
	output gamePkg::imageAddr_t menuAddr,
	output gamePkg::spriteAddr_t spriteAddr,
	output logic inSprite,
	output logic offMap
);

	import gamePkg::*;

	int px;
	int py;
	int mx;
	int my;

	// Sheet column of the frame for this facing and step
	function automatic int columnBase(input direction_t facing, input walkStep_t step);
		int base;
		int offset;
		case (facing)
			dirDown: base = 0;
			dirLeft: base = 3 * spriteW;
			dirUp: base = 6 * spriteW;
			default: base = 9 * spriteW;
		endcase
		case (step)
			stepMove1: offset = 0;
			stepMove2: offset = 2 * spriteW;
			default: offset = spriteW;
		endcase
		return base + offset;
	endfunction

	always_comb begin
		px = int'(drawX);
		py = int'(drawY);
		mx = px + int'(view.camX);
		my = py + int'(view.camY);

		offMap = (mx < 0) || (my < 0) || (mx / mapScale >= mapW) || (my / mapScale >= mapH);

		if (mx < 0 || my < 0) begin
			mapAddr = '0;
		end else begin
			mapAddr = imageAddr_t'((my / mapScale) * mapW + mx / mapScale);
		end

		menuAddr = imageAddr_t'((py / menuScale) * mapW + px / menuScale);

		inSprite = (px >= spriteX0) && (px < spriteX0 + spriteW) &&
			(py >= spriteY0) && (py < spriteY0 + spriteH);

		if (inSprite) begin
			spriteAddr = spriteAddr_t'(sheetW * (py - spriteY0) + (px - spriteX0) +
				columnBase(view.facing, view.step));
		end else begin
			spriteAddr = '0;
		end
	end

endmodule

//--- sceneController.sv
`timescale 1ns/1ps

module sceneController (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic [7:0] keycode,
	input logic moving,
	input gamePkg::direction_t direction,
	output gamePkg::sceneView_t view
);

	import gamePkg::*;

	localparam int DelayBits = $clog2(stepDelay);

	gameState_t gameState;
	direction_t facing;
	walkStep_t step;
	logic [DelayBits-1:0] delayCount;
	camCoord_t camX;
	camCoord_t camY;

	function automatic walkStep_t nextStep(input walkStep_t cur);
		walkStep_t nxt;
		case (cur)
			stepRest1: nxt = stepMove1;
			stepMove1: nxt = stepRest2;
			stepRest2: nxt = stepMove2;
			default: nxt = stepRest1;
		endcase
		return nxt;
	endfunction

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			gameState <= stateStart;
			facing <= dirUp;
			step <= stepRest1;
			delayCount <= '0;
			camX <= camStart;
			camY <= camStart;
		end else if (frameTick) begin
			case (gameState)
				stateStart: begin
					if (keycode == startKey) begin
						gameState <= stateOverworld;
						camX <= camStart;
						camY <= camStart;
					end
				end
				default: begin
					if (!moving) begin
						step <= stepRest1;
					end else if (direction != facing) begin
						// Turn in place
						facing <= direction;
						step <= stepRest1;
					end else begin
						if (delayCount == DelayBits'(stepDelay - 1)) begin
							delayCount <= '0;
						end else begin
							delayCount <= delayCount + 1'b1;
						end
						if (delayCount == '0) begin
							step <= nextStep(step);
						end
						// Scroll one pixel per tick up to the limits
						case (facing)
							dirUp: begin
								if (camY > camMinY) begin
									camY <= camY - camCoord_t'(1);
								end
							end
							dirDown: begin
								if (camY < camMaxY) begin
									camY <= camY + camCoord_t'(1);
								end
							end
							dirLeft: begin
								if (camX > camMinX) begin
									camX <= camX - camCoord_t'(1);
								end
							end
							default: begin
								if (camX < camMaxX) begin
									camX <= camX + camCoord_t'(1);
								end
							end
						endcase
					end
				end
			endcase
		end
	end

	assign view = '{
		overworld: (gameState == stateOverworld),
		camX: camX,
		camY: camY,
		facing: facing,
		step: step
	};

endmodule

//--- frameMemory.sv
`timescale 1ns/1ps

module frameMemory #(
	parameter int Depth = 256,
	parameter int Width = 8
) (
	input logic Clk,
	input logic we,
	input gamePkg::imageAddr_t writeAddr,
	input logic [Width-1:0] writeData,
	input gamePkg::imageAddr_t readAddr,
	output logic [Width-1:0] readData
);

	localparam int AddrBits = $clog2(Depth);

	logic [Width-1:0] mem [Depth];

	always_ff @(posedge Clk) begin
		if (we && int'(writeAddr) < Depth) begin
			mem[writeAddr[AddrBits-1:0]] <= writeData;
		end
		// Addresses past the end read as index 0
		if (int'(readAddr) < Depth) begin
			readData <= mem[readAddr[AddrBits-1:0]];
		end else begin
			readData <= '0;
		end
	end

endmodule

//--- gamePkg.sv
package gamePkg;

	// Widths that carry a meaning
	typedef logic [10:0] screenCoord_t;
	typedef logic signed [12:0] camCoord_t;
	typedef logic [12:0] spriteAddr_t;
	typedef logic [16:0] imageAddr_t;
	typedef logic [7:0] colorIndex_t;
	typedef logic [3:0] spriteIndex_t;
	typedef logic [23:0] rgb_t;

	typedef enum logic {
		stateStart,
		stateOverworld
	} gameState_t;

	// Codes match the Direction input encoding
	typedef enum logic [1:0] {
		dirUp = 2'd0,
		dirRight = 2'd1,
		dirDown = 2'd2,
		dirLeft = 2'd3
	} direction_t;

	typedef enum logic [1:0] {
		stepRest1,
		stepMove1,
		stepRest2,
		stepMove2
	} walkStep_t;

	typedef enum logic [1:0] {
		targetSprite,
		targetMap,
		targetMenu,
		targetPalette
	} memTarget_t;

	typedef struct packed {
		logic valid;
		memTarget_t target;
		imageAddr_t addr;
		rgb_t data;
	} loadReq_t;

	typedef struct packed {
		logic overworld;
		camCoord_t camX;
		camCoord_t camY;
		direction_t facing;
		walkStep_t step;
	} sceneView_t;

	// Character window on screen
	localparam int spriteX0 = 311;
	localparam int spriteY0 = 340;
	localparam int spriteW = 19;
	localparam int spriteH = 29;
	localparam int sheetW = 228;

	localparam int mapW = 320;
	localparam int mapH = 240;
	localparam int mapScale = 4;
	localparam int menuScale = 2;

	localparam logic [7:0] startKey = 8'h2c;

	localparam camCoord_t camStart = 13'sd100;
	localparam camCoord_t camMinX = -13'sd311;
	localparam camCoord_t camMaxX = 13'sd952;
	localparam camCoord_t camMinY = -13'sd340;
	localparam camCoord_t camMaxY = 13'sd595;

	// Ticks per walk frame
	localparam int stepDelay = 8;

endpackage
